/* hdl/erx_defines.svh */
// FIFO depth, prog-full level, translation table size and read-response window macros
`ifndef ERX_DEFINES_SVH
`define ERX_DEFINES_SVH

`default_nettype none

// Queue geometry
`define ERX_FIFO_DEPTH   16      // Entries per queue
`define ERX_PROG_FULL    12      // Push-back at this count or above

// Address translation
`define ERX_MMU_ENTRIES  16      // Indexed by dstaddr[31:28]

// Writes landing here are read responses
`define ERX_RR_WINDOW    12'h810 // Compared against dstaddr[31:20]

`default_nettype wire

`endif

/* hdl/erx_pkg.sv */
// Package erx_pkg with mesh field types, packed transaction and protocol FSM states
`default_nettype none

package erx_pkg;

   typedef logic [3:0]  ctrlmode_t;   // Control mode
   typedef logic [1:0]  datamode_t;   // Size code
   typedef logic [31:0] addr_t;       // Byte address
   typedef logic [31:0] data_t;       // Data word
   typedef logic [63:0] beat_t;       // One link beat after deserialization

   // 103 bits, MSB first
   typedef struct packed {
      ctrlmode_t ctrlmode;            // [102:99]
      logic      write;               // [98]
      datamode_t datamode;            // [97:96]
      addr_t     dstaddr;             // [95:64]
      addr_t     srcaddr;             // [63:32]
      data_t     data;                // [31:0]
   } emesh_pkt_t;

   // Role of the next framed beat
   typedef enum logic [1:0] {
      proto_idle    = 2'd0,           // Link quiet, next framed beat is a header
      proto_header  = 2'd1,           // Just finished a pair, frame may continue
      proto_payload = 2'd2            // Header held, payload expected
   } proto_state_t;

endpackage

`default_nettype wire

/* hdl/erx_protocol.sv */
// Module erx_protocol: beat capture, header/payload pairing FSM and link wait registers
`default_nettype none

module erx_protocol
(
   input  wire                     rxlclk_p,
   input  wire                     rst_n,
   input  wire                     rx_frame,
   input  wire erx_pkg::beat_t     rx_data,
   input  wire                     wr_wait_in,      // From distributor
   input  wire                     rd_wait_in,
   output logic                    rx_wr_wait,      // To link pins
   output logic                    rx_rd_wait,
   output logic                    prot_access,     // One-cycle strobe
   output erx_pkg::ctrlmode_t      prot_ctrlmode,
   output logic                    prot_write,
   output erx_pkg::datamode_t      prot_datamode,
   output erx_pkg::addr_t          prot_dstaddr,
   output erx_pkg::addr_t          prot_srcaddr,
   output erx_pkg::data_t          prot_data
);

   import erx_pkg::*;

   logic          frame_q;          // Captured frame
   beat_t         beat_q;           // Captured beat
   proto_state_t  state;            // Pairing FSM
   ctrlmode_t     hdr_ctrlmode;     // Held header fields
   logic          hdr_write;
   datamode_t     hdr_datamode;
   addr_t         hdr_dstaddr;
   logic          take_hdr;         // Current framed beat is a header
   logic          take_pld;         // Current framed beat completes a pair

   assign take_pld = frame_q && (state == proto_payload);
   assign take_hdr = frame_q && (state != proto_payload);

   // Input capture stage
   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
         frame_q <= 1'b0;
      else
         frame_q <= rx_frame;
      beat_q <= rx_data;
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
         state <= proto_idle;
      else
      begin
         case (state)
            proto_idle, proto_header:
               state <= frame_q ? proto_payload : proto_idle;
            proto_payload:
               state <= frame_q ? proto_header : proto_idle;   // Gap drops the header
            default:
               state <= proto_idle;
         endcase
      end
   end

   // Header fields wait here for their payload
   always_ff @(posedge rxlclk_p)
   begin
      if (take_hdr)
      begin
         hdr_ctrlmode <= beat_q[63:60];
         hdr_write    <= beat_q[59];
         hdr_datamode <= beat_q[58:57];
         hdr_dstaddr  <= beat_q[31:0];   // Bits 56..32 reserved
      end
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
         prot_access <= 1'b0;
      else
         prot_access <= take_pld;
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (take_pld)
      begin
         prot_ctrlmode <= hdr_ctrlmode;
         prot_write    <= hdr_write;
         prot_datamode <= hdr_datamode;
         prot_dstaddr  <= hdr_dstaddr;
         prot_srcaddr  <= beat_q[31:0];   // Payload low half
         prot_data     <= beat_q[63:32];  // Payload high half
      end
   end

   // Push-back toward the sender
   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
      begin
         rx_wr_wait <= 1'b0;
         rx_rd_wait <= 1'b0;
      end
      else
      begin
         rx_wr_wait <= wr_wait_in;
         rx_rd_wait <= rd_wait_in;
      end
   end

   // A header beat is always followed directly by its payload
   a_frame_held: assert property (@(posedge rxlclk_p) disable iff (!rst_n)
      take_hdr |=> frame_q)
      else $error("erx_protocol: frame dropped between header and payload");

endmodule

`default_nettype wire

/* hdl/erx_mmu.sv */
// Module erx_mmu: APB translation table and registered destination remap stage
`include "erx_defines.svh"
`default_nettype none

module erx_mmu
(
   input  wire                     rxlclk_p,
   input  wire                     rst_n,
   input  wire                     mmu_en,          // Translation on
   input  wire                     psel,            // APB
   input  wire                     penable,
   input  wire                     pwrite,
   input  wire [5:0]               paddr,
   input  wire erx_pkg::data_t     pwdata,
   output erx_pkg::data_t          prdata,
   input  wire                     prot_access,     // From protocol
   input  wire erx_pkg::ctrlmode_t prot_ctrlmode,
   input  wire                     prot_write,
   input  wire erx_pkg::datamode_t prot_datamode,
   input  wire erx_pkg::addr_t     prot_dstaddr,
   input  wire erx_pkg::addr_t     prot_srcaddr,
   input  wire erx_pkg::data_t     prot_data,
   output logic                    mmu_access,      // To distributor
   output erx_pkg::emesh_pkt_t     mmu_pkt
);

   import erx_pkg::*;

   localparam int idx_w = $clog2(`ERX_MMU_ENTRIES);

   logic [11:0]       xlat_tbl [`ERX_MMU_ENTRIES];  // Upper address per region
   logic [idx_w-1:0]  apb_idx;                      // Entry from paddr[5:2]
   logic [idx_w-1:0]  map_idx;                      // Entry from dstaddr top nibble
   logic              apb_wr;                       // Access-phase write
   logic              apb_rd;                       // Access-phase read
   addr_t             xlat_dstaddr;                 // Remapped destination

   assign apb_idx = paddr[2 +: idx_w];
   assign apb_wr  = psel && penable && pwrite;
   assign apb_rd  = psel && penable && !pwrite;

   // Table writes complete in the access cycle
   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `ERX_MMU_ENTRIES; i++)
            xlat_tbl[i] <= 12'h000;
      end
      else if (apb_wr)
         xlat_tbl[apb_idx] <= pwdata[11:0];
   end

   // Zero wait-state read data
   always_comb
   begin
      if (apb_rd)
         prdata = {20'h00000, xlat_tbl[apb_idx]};
      else
         prdata = '0;
   end

   // Top nibble selects the entry, low 20 bits untouched
   assign map_idx = prot_dstaddr[31 -: idx_w];

   always_comb
   begin
      if (mmu_en)
         xlat_dstaddr = {xlat_tbl[map_idx], prot_dstaddr[19:0]};
      else
         xlat_dstaddr = prot_dstaddr;
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
         mmu_access <= 1'b0;
      else
         mmu_access <= prot_access;
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (prot_access)
      begin
         mmu_pkt.ctrlmode <= prot_ctrlmode;
         mmu_pkt.write    <= prot_write;
         mmu_pkt.datamode <= prot_datamode;
         mmu_pkt.dstaddr  <= xlat_dstaddr;
         mmu_pkt.srcaddr  <= prot_srcaddr;
         mmu_pkt.data     <= prot_data;
      end
   end

endmodule

`default_nettype wire

/* hdl/erx_disty.sv */
// Module erx_disty: queue selection for transactions and push-back from fill levels
`include "erx_defines.svh"
`default_nettype none

module erx_disty
(
   input  wire                     rxlclk_p,
   input  wire                     rst_n,
   input  wire                     rx_enable,       // Receiver on
   input  wire                     mmu_access,
   input  wire erx_pkg::emesh_pkt_t mmu_pkt,
   input  wire                     wr_full,         // Write queue
   input  wire                     rq_full,         // Read request queue
   input  wire                     rr_full,         // Read response queue
   input  wire                     wr_prog_full,
   input  wire                     rq_prog_full,
   input  wire                     rr_prog_full,
   output logic                    wr_wr_en,
   output logic                    rq_wr_en,
   output logic                    rr_wr_en,
   output erx_pkg::emesh_pkt_t     fifo_data,       // Shared by all queues
   output logic                    wr_wait,         // To protocol
   output logic                    rd_wait
);

   logic is_wr;       // Plain write
   logic is_rq;       // Read request
   logic is_rr;       // Write into response window
   logic tgt_full;    // Selected queue has no room
   logic accept;      // Transaction goes to a queue

   assign is_rq    = !mmu_pkt.write;
   assign is_rr    = mmu_pkt.write && (mmu_pkt.dstaddr[31:20] == `ERX_RR_WINDOW);
   assign is_wr    = mmu_pkt.write && !is_rr;
   assign tgt_full = (is_wr && wr_full) || (is_rq && rq_full) || (is_rr && rr_full);
   assign accept   = mmu_access && rx_enable && !tgt_full;   // Otherwise dropped

   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
      begin
         wr_wr_en <= 1'b0;
         rq_wr_en <= 1'b0;
         rr_wr_en <= 1'b0;
      end
      else
      begin
         wr_wr_en <= accept && is_wr;
         rq_wr_en <= accept && is_rq;
         rr_wr_en <= accept && is_rr;
      end
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (mmu_access)
         fifo_data <= mmu_pkt;
   end

   // Responses share the write-side wait
   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
      begin
         wr_wait <= 1'b0;
         rd_wait <= 1'b0;
      end
      else
      begin
         wr_wait <= wr_prog_full || rr_prog_full;
         rd_wait <= rq_prog_full;
      end
   end

   // Sender ignored push-back and a queue overflowed
   a_no_full_drop: assert property (@(posedge rxlclk_p) disable iff (!rst_n)
      (mmu_access && rx_enable) |-> !tgt_full)
      else $error("erx_disty: transaction dropped, target queue full");

endmodule

`default_nettype wire

/* hdl/erx_fifo.sv */
// Module erx_fifo: single-clock first-word-fall-through queue with full and prog-full
`include "erx_defines.svh"
`default_nettype none

module erx_fifo
#(
   parameter int DEPTH = `ERX_FIFO_DEPTH
)
(
   input  wire                      rxlclk_p,
   input  wire                      rst_n,
   input  wire                      wr_en,
   input  wire erx_pkg::emesh_pkt_t wr_data,
   input  wire                      rd_en,          // Pops the head
   output erx_pkg::emesh_pkt_t      rd_data,        // Head, valid while not empty
   output logic                     empty,
   output logic                     full,
   output logic                     prog_full       // Count at threshold or above
);

   import erx_pkg::*;

   localparam int aw = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int cw = $clog2(DEPTH + 1);

   emesh_pkt_t       mem [DEPTH];   // Storage
   logic [aw-1:0]    wr_ptr;        // Next free slot
   logic [aw-1:0]    rd_ptr;        // Head slot
   logic [cw-1:0]    count;         // Occupancy
   logic             do_wr;
   logic             do_rd;

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   always_ff @(posedge rxlclk_p)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge rxlclk_p)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= (wr_ptr == aw'(DEPTH - 1)) ? '0 : wr_ptr + aw'(1);   // Wrap
         if (do_rd)
            rd_ptr <= (rd_ptr == aw'(DEPTH - 1)) ? '0 : rd_ptr + aw'(1);
         if (do_wr && !do_rd)
            count <= count + cw'(1);
         else if (do_rd && !do_wr)
            count <= count - cw'(1);
      end
   end

   // Flags straight from the count
   assign rd_data   = mem[rd_ptr];
   assign empty     = (count == '0);
   assign full      = (count == cw'(DEPTH));
   assign prog_full = (count >= cw'(`ERX_PROG_FULL));

   a_no_wr_full: assert property (@(posedge rxlclk_p) disable iff (!rst_n)
      wr_en |-> !full)
      else $error("erx_fifo: write while full");

   a_no_rd_empty: assert property (@(posedge rxlclk_p) disable iff (!rst_n)
      rd_en |-> !empty)
      else $error("erx_fifo: read while empty");

endmodule

`default_nettype wire

/* hdl/erx.sv */
// Module erx: receive path top with protocol, translation, distributor and three queues
`include "erx_defines.svh"
`default_nettype none

module erx
(
   input  wire                     rxlclk_p,
   input  wire                     rst_n,
   input  wire                     rx_enable,
   input  wire                     mmu_en,
   input  wire                     rx_frame,        // Link side
   input  wire erx_pkg::beat_t     rx_data,
   output logic                    rx_wr_wait,
   output logic                    rx_rd_wait,
   input  wire                     psel,            // Table access
   input  wire                     penable,
   input  wire                     pwrite,
   input  wire [5:0]               paddr,
   input  wire erx_pkg::data_t     pwdata,
   output erx_pkg::data_t          prdata,
   input  wire                     wr_rd_en,        // Write queue drain
   output logic                    wr_empty,
   output erx_pkg::emesh_pkt_t     wr_rd_data,
   input  wire                     rq_rd_en,        // Read request drain
   output logic                    rq_empty,
   output erx_pkg::emesh_pkt_t     rq_rd_data,
   input  wire                     rr_rd_en,        // Read response drain
   output logic                    rr_empty,
   output erx_pkg::emesh_pkt_t     rr_rd_data
);

   import erx_pkg::*;

   logic        prot_access;      // Protocol to MMU
   ctrlmode_t   prot_ctrlmode;
   logic        prot_write;
   datamode_t   prot_datamode;
   addr_t       prot_dstaddr;
   addr_t       prot_srcaddr;
   data_t       prot_data;
   logic        mmu_access;       // MMU to distributor
   emesh_pkt_t  mmu_pkt;
   emesh_pkt_t  fifo_data;        // Distributor to queues
   logic        wr_wr_en, rq_wr_en, rr_wr_en;
   logic        wr_full, rq_full, rr_full;
   logic        wr_prog_full, rq_prog_full, rr_prog_full;
   logic        disty_wr_wait;    // Back to protocol
   logic        disty_rd_wait;

   erx_protocol protocol (
      .rxlclk_p(rxlclk_p), .rst_n(rst_n), .rx_frame(rx_frame), .rx_data(rx_data),
      .wr_wait_in(disty_wr_wait), .rd_wait_in(disty_rd_wait),
      .rx_wr_wait(rx_wr_wait), .rx_rd_wait(rx_rd_wait),
      .prot_access(prot_access), .prot_ctrlmode(prot_ctrlmode), .prot_write(prot_write),
      .prot_datamode(prot_datamode), .prot_dstaddr(prot_dstaddr),
      .prot_srcaddr(prot_srcaddr), .prot_data(prot_data));

   erx_mmu mmu (
      .rxlclk_p(rxlclk_p), .rst_n(rst_n), .mmu_en(mmu_en),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata),
      .prot_access(prot_access), .prot_ctrlmode(prot_ctrlmode), .prot_write(prot_write),
      .prot_datamode(prot_datamode), .prot_dstaddr(prot_dstaddr),
      .prot_srcaddr(prot_srcaddr), .prot_data(prot_data),
      .mmu_access(mmu_access), .mmu_pkt(mmu_pkt));

   erx_disty disty (
      .rxlclk_p(rxlclk_p), .rst_n(rst_n), .rx_enable(rx_enable),
      .mmu_access(mmu_access), .mmu_pkt(mmu_pkt),
      .wr_full(wr_full), .rq_full(rq_full), .rr_full(rr_full),
      .wr_prog_full(wr_prog_full), .rq_prog_full(rq_prog_full),
      .rr_prog_full(rr_prog_full),
      .wr_wr_en(wr_wr_en), .rq_wr_en(rq_wr_en), .rr_wr_en(rr_wr_en),
      .fifo_data(fifo_data), .wr_wait(disty_wr_wait), .rd_wait(disty_rd_wait));

   // Plain writes
   erx_fifo #(.DEPTH(`ERX_FIFO_DEPTH)) wr_fifo (
      .rxlclk_p(rxlclk_p), .rst_n(rst_n), .wr_en(wr_wr_en), .wr_data(fifo_data),
      .rd_en(wr_rd_en), .rd_data(wr_rd_data), .empty(wr_empty),
      .full(wr_full), .prog_full(wr_prog_full));

   // Read requests
   erx_fifo #(.DEPTH(`ERX_FIFO_DEPTH)) rq_fifo (
      .rxlclk_p(rxlclk_p), .rst_n(rst_n), .wr_en(rq_wr_en), .wr_data(fifo_data),
      .rd_en(rq_rd_en), .rd_data(rq_rd_data), .empty(rq_empty),
      .full(rq_full), .prog_full(rq_prog_full));

   // Read responses
   erx_fifo #(.DEPTH(`ERX_FIFO_DEPTH)) rr_fifo (
      .rxlclk_p(rxlclk_p), .rst_n(rst_n), .wr_en(rr_wr_en), .wr_data(fifo_data),
      .rd_en(rr_rd_en), .rd_data(rr_rd_data), .empty(rr_empty),
      .full(rr_full), .prog_full(rr_prog_full));

endmodule

`default_nettype wire

/* verification/erx_tb.sv */
// Testbench erx_tb: clock, reset, APB access, link driver, queue drains and compare tasks
`default_nettype none

module erx_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import erx_pkg::*;

   localparam int timeout_cycles = 200;   // Per wait loop
   localparam int settle_cycles  = 8;     // Pipeline is 4 deep

   logic        rxlclk_p;
   logic        rst_n;
   logic        rx_enable;
   logic        mmu_en;
   logic        rx_frame;
   beat_t       rx_data;
   logic        rx_wr_wait;
   logic        rx_rd_wait;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [5:0]  paddr;
   data_t       pwdata;
   data_t       prdata;
   logic        wr_rd_en, rq_rd_en, rr_rd_en;
   logic        wr_empty, rq_empty, rr_empty;
   emesh_pkt_t  wr_rd_data, rq_rd_data, rr_rd_data;

   emesh_pkt_t  exp_wr[$];      // Expected queue contents
   emesh_pkt_t  exp_rq[$];
   emesh_pkt_t  exp_rr[$];
   int          errors;
   int          seed;           // Fill data source
   logic        in_group;       // Packets sent, not yet drained

   erx uut (
      .rxlclk_p(rxlclk_p), .rst_n(rst_n), .rx_enable(rx_enable), .mmu_en(mmu_en),
      .rx_frame(rx_frame), .rx_data(rx_data), .rx_wr_wait(rx_wr_wait), .rx_rd_wait(rx_rd_wait),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata),
      .wr_rd_en(wr_rd_en), .wr_empty(wr_empty), .wr_rd_data(wr_rd_data),
      .rq_rd_en(rq_rd_en), .rq_empty(rq_empty), .rq_rd_data(rq_rd_data),
      .rr_rd_en(rr_rd_en), .rr_empty(rr_empty), .rr_rd_data(rr_rd_data));

   initial
   begin
      rxlclk_p = 1'b0;
      forever #2 rxlclk_p = ~rxlclk_p;   // 4 ns period
   end

   task automatic stop_on_error();
      errors++;
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic abort_run(input string msg);
      $display("ERROR: %s", msg);
      stop_on_error();
   endtask

   task automatic check_pkt(input string name, input emesh_pkt_t got, input emesh_pkt_t exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   function automatic emesh_pkt_t make_pkt(input ctrlmode_t c, input logic w, input datamode_t dm,
                                          input addr_t dst, input addr_t src, input data_t dat);
      emesh_pkt_t p;
      p.ctrlmode = c;
      p.write    = w;
      p.datamode = dm;
      p.dstaddr  = dst;
      p.srcaddr  = src;
      p.data     = dat;
      return p;
   endfunction

   function automatic logic queue_empty(input logic [1:0] q);
      case (q)
         2'd1:    return wr_empty;
         2'd2:    return rq_empty;
         default: return rr_empty;
      endcase
   endfunction

   task automatic push_expected(input logic [1:0] q, input emesh_pkt_t p);
      case (q)
         2'd1:    exp_wr.push_back(p);
         2'd2:    exp_rq.push_back(p);
         2'd3:    exp_rr.push_back(p);
         default: ;                           // Dropped, nothing expected
      endcase
   endtask

   task automatic apb_write(input logic [5:0] addr, input data_t data);
      psel    = 1'b1;                         // Setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge rxlclk_p);
      penable = 1'b1;                         // Access phase, no wait states
      @(negedge rxlclk_p);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [5:0] addr, output data_t data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge rxlclk_p);
      penable = 1'b1;
      #1 data = prdata;                       // Mid access cycle
      @(negedge rxlclk_p);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic send_packet(input beat_t hdr, input beat_t pld);
      int waited;
      waited = 0;
      while (rx_wr_wait || rx_rd_wait)        // No new header under push-back
      begin
         if (waited == timeout_cycles)
            abort_run("link push-back never released before a new header");
         rx_frame = 1'b0;
         @(negedge rxlclk_p);
         waited++;
      end
      rx_frame = 1'b1;
      rx_data  = hdr;
      @(negedge rxlclk_p);
      rx_data  = pld;
      @(negedge rxlclk_p);                    // Frame stays up for the next pair
   endtask

   task automatic pop_entry(input logic [1:0] q, output emesh_pkt_t got);
      int waited;
      waited = 0;
      while (queue_empty(q))
      begin
         if (waited == timeout_cycles)
            abort_run($sformatf("queue %0d never delivered an expected entry", q));
         @(negedge rxlclk_p);
         waited++;
      end
      case (q)
         2'd1:    got = wr_rd_data;           // Head is visible while not empty
         2'd2:    got = rq_rd_data;
         default: got = rr_rd_data;
      endcase
      wr_rd_en = (q == 2'd1);
      rq_rd_en = (q == 2'd2);
      rr_rd_en = (q == 2'd3);
      @(negedge rxlclk_p);
      wr_rd_en = 1'b0;
      rq_rd_en = 1'b0;
      rr_rd_en = 1'b0;
   endtask

   task automatic await_pin(input logic rd_side, input logic level);
      int waited;
      waited = 0;
      while ((rd_side ? rx_rd_wait : rx_wr_wait) !== level)
      begin
         if (waited == timeout_cycles)
            abort_run($sformatf("%s never reached %0b",
                                rd_side ? "rx_rd_wait" : "rx_wr_wait", level));
         @(negedge rxlclk_p);
         waited++;
      end
   endtask

   // Close the frame, drain every queue in order, then nothing may be left
   task automatic finish_group();
      emesh_pkt_t got;
      emesh_pkt_t exp;
      rx_frame = 1'b0;
      rx_data  = '0;
      while (exp_wr.size() > 0)
      begin
         pop_entry(2'd1, got);
         exp = exp_wr.pop_front();
         check_pkt("wr_rd_data", got, exp);
      end
      while (exp_rq.size() > 0)
      begin
         pop_entry(2'd2, got);
         exp = exp_rq.pop_front();
         check_pkt("rq_rd_data", got, exp);
      end
      while (exp_rr.size() > 0)
      begin
         pop_entry(2'd3, got);
         exp = exp_rr.pop_front();
         check_pkt("rr_rd_data", got, exp);
      end
      repeat (settle_cycles) @(negedge rxlclk_p);
      check_bit("wr_empty", wr_empty, 1'b1);
      check_bit("rq_empty", rq_empty, 1'b1);
      check_bit("rr_empty", rr_empty, 1'b1);
      in_group = 1'b0;
   endtask

   // Load one queue to prog-full without draining, watch push-back rise and fall
   task automatic fill_queue(input logic [1:0] q, input int count);
      logic  rd_side;
      data_t rnd;
      addr_t dst;
      beat_t hdr;
      int    i;
      rd_side   = (q == 2'd2);
      mmu_en    = 1'b0;
      rx_enable = 1'b1;
      for (i = 0; i < count; i++)
      begin
         if (q == 2'd3)
            dst = 32'h8100_0000 + 32'(i * 4);    // Inside the response window
         else
            dst = 32'h0010_0000 + 32'(i * 4);    // Outside the response window
         rnd = $random(seed);
         hdr = {4'h9, !rd_side, 2'b10, 25'h0, dst};
         push_expected(q, make_pkt(hdr[63:60], hdr[59], hdr[58:57], hdr[31:0], 32'(i), rnd));
         send_packet(hdr, {rnd, 32'(i)});
      end
      rx_frame = 1'b0;
      await_pin(rd_side, 1'b1);
      check_bit(rd_side ? "rx_wr_wait" : "rx_rd_wait", rd_side ? rx_wr_wait : rx_rd_wait, 1'b0);
      finish_group();
      await_pin(rd_side, 1'b0);               // Released once drained
   endtask

   task automatic process_record(input string line);
      logic [63:0] kind;
      logic [63:0] c1, c2, c3, c4, c5, c6, c7, c8, c9, c10, c11;
      data_t       rd;
      int          n;
      n = $sscanf(line, "%h", kind);
      if (n != 1)
         abort_run("stimulus line without a record kind");
      if (in_group && kind != 64'd3)
         finish_group();
      case (kind)
         64'd1, 64'd2:
         begin
            n = $sscanf(line, "%h %h %h %h", kind, c1, c2, c3);
            if (n != 4)
               abort_run("malformed APB record");
            if (kind == 64'd1)
               apb_write(c1[5:0], c2[31:0]);
            apb_read(c1[5:0], rd);
            check_data("prdata", rd, c3[31:0]);
         end
         64'd3:
         begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        kind, c1, c2, c3, c4, c5, c6, c7, c8, c9, c10, c11);
            if (n != 12)
               abort_run("malformed packet record");
            if (in_group && (mmu_en != c1[0] || rx_enable != c2[0]))
               finish_group();                // Mode changes only on an idle pipe
            mmu_en    = c1[0];
            rx_enable = c2[0];
            push_expected(c5[1:0], make_pkt(c6[3:0], c7[0], c8[1:0], c9[31:0],
                                            c10[31:0], c11[31:0]));
            send_packet(c3, c4);
            in_group = 1'b1;
         end
         64'd4:
         begin
            n = $sscanf(line, "%h %h %h", kind, c1, c2);
            if (n != 3)
               abort_run("malformed fill record");
            fill_queue(c1[1:0], int'(c2[7:0]));
         end
         default:
            abort_run("unknown stimulus record kind");
      endcase
   endtask

   task automatic run_stimulus();
      string line;
      int    fd;
      int    n;
      fd = $fopen("verification/erx_stim.txt", "r");
      if (fd == 0)
         abort_run("cannot open verification/erx_stim.txt");
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line[0] != "#")   // Skip comments and blanks
            process_record(line);
      end
      $fclose(fd);
      if (in_group)
         finish_group();
   endtask

   initial
   begin
      errors    = 0;
      seed      = 32'h1545c545;
      in_group  = 1'b0;
      rst_n     = 1'b0;
      rx_enable = 1'b0;
      mmu_en    = 1'b0;
      rx_frame  = 1'b0;
      rx_data   = '0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      wr_rd_en  = 1'b0;
      rq_rd_en  = 1'b0;
      rr_rd_en  = 1'b0;
      repeat (16) @(negedge rxlclk_p);
      check_bit("wr_empty", wr_empty, 1'b1);          // Reset state
      check_bit("rq_empty", rq_empty, 1'b1);
      check_bit("rr_empty", rr_empty, 1'b1);
      check_bit("rx_wr_wait", rx_wr_wait, 1'b0);
      check_bit("rx_rd_wait", rx_rd_wait, 1'b0);
      rst_n = 1'b1;
      @(negedge rxlclk_p);
      run_stimulus();
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verification/erx_stim.txt */
# kind 1 APB write and read back: paddr pwdata expected / kind 2 APB read: paddr 0 expected
# kind 3 packet: mmu_en rx_enable header payload queue ctrlmode write datamode dst src data
# kind 4 fill: queue count (queue 1 write, 2 read request, 3 read response, 0 dropped)
1 04 DEAD05A5 5A5
1 20 00000810 810
1 3C FFFFFFFF FFF
2 0C 0 0
2 00 0 0
# Translation off, one packet per queue, back to back
3 0 1 5C12345612345678 CAFEF00D00001000 1 5 1 2 12345678 00001000 CAFEF00D
3 0 1 3300000020000040 8100020030000010 2 3 0 1 20000040 30000010 81000200
3 0 1 0E00000081000008 600DCAFE40000004 3 0 1 3 81000008 40000004 600DCAFE
# Translation on, five back-to-back packets
3 1 1 2C0000001ABCDEF0 1111111100000001 1 2 1 2 5A5CDEF0 00000001 11111111
3 1 1 1800000087654320 2222222200000002 3 1 1 0 81054320 00000002 22222222
3 1 1 74000000F0000100 3333333300000003 2 7 0 2 FFF00100 00000003 33333333
3 1 1 FB7FFFFF30040000 4444444400000004 1 F 1 1 00040000 00000004 44444444
3 1 1 4E00000010000004 5555555500000005 1 4 1 3 5A500004 00000005 55555555
# Receiver disabled, packet dropped
3 0 0 5C00000000000100 1234567800000000 0 0 0 0 0 0 0
# Back-pressure, 12 entries reach prog-full
4 1 C
4 2 C

/* files.f */
+incdir+hdl
hdl/erx_pkg.sv
hdl/erx_protocol.sv
hdl/erx_mmu.sv
hdl/erx_disty.sv
hdl/erx_fifo.sv
hdl/erx.sv
verification/erx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the erx testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module erx_tb -f files.f -o erx_sim > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/erx_sim > sim.log 2>&1
status=$?
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "Run failed"; exit 1; }
[ "$status" -eq 0 ] || { echo "Simulator exited with status $status"; exit 1; }
exit 0
